//--- src/slv_guard_pkg.sv
// Slave guard package with bus widths, AXI4-Lite and APB structs and register map
package slv_guard_pkg;

  // Bus widths
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  localparam int unsigned RegAddrWidth = 8;

  // AXI4-Lite channel payloads
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
  } axil_ar_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [1:0]           resp;
  } axil_r_t;

  // Manager driven side of the port
  typedef struct packed {
    axil_aw_t aw;
    logic     aw_valid;
    axil_w_t  w;
    logic     w_valid;
    logic     b_ready;
    axil_ar_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axil_req_t;

  // Subordinate driven side of the port
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    axil_b_t b;
    logic    b_valid;
    logic    ar_ready;
    axil_r_t r;
    logic    r_valid;
  } axil_rsp_t;

  // APB register bus
  typedef struct packed {
    logic [RegAddrWidth-1:0] paddr;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [DataWidth-1:0]    pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] prdata;
    logic                 pready;
    logic                 pslverr;
  } apb_rsp_t;

  // Register file to monitors
  typedef struct packed {
    logic [31:0] budget_write;
    logic [31:0] budget_read;
  } guard_cfg_t;

  // Monitor to register file, one per direction
  typedef struct packed {
    logic                 timeout;
    logic [AddrWidth-1:0] addr;
  } guard_evt_t;

  // Register offsets
  localparam logic [RegAddrWidth-1:0] RegBudgetWr  = 8'h00;
  localparam logic [RegAddrWidth-1:0] RegBudgetRd  = 8'h04;
  localparam logic [RegAddrWidth-1:0] RegIrqStatus = 8'h08;
  localparam logic [RegAddrWidth-1:0] RegIrqAddr   = 8'h0C;
  localparam logic [RegAddrWidth-1:0] RegReset     = 8'h10;

endpackage

//--- src/slv_guard_regs.sv
// Slave guard register file on APB with budgets, sticky timeout status and captured address
module slv_guard_regs import slv_guard_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  // APB register bus
  input  apb_req_t   reg_req_i,
  output apb_rsp_t   reg_rsp_o,
  // Budgets to the monitors
  output guard_cfg_t cfg_o,
  // Timeout events from the monitors
  input  guard_evt_t evt_wr_i,
  input  guard_evt_t evt_rd_i,
  // Live reset request state
  input  logic       rst_pending_i,
  output logic       irq_o
);

  logic                 access;
  logic                 wr_access;
  logic                 mapped;
  logic [31:0]          budget_wr_q;
  logic [31:0]          budget_rd_q;
  logic [1:0]           status_q;
  logic [1:0]           status_set;
  logic [1:0]           status_clr;
  logic [AddrWidth-1:0] irq_addr_q;
  logic                 irq_q;

  // Access phase of an APB transfer
  assign access    = reg_req_i.psel && reg_req_i.penable;
  assign wr_access = access && reg_req_i.pwrite;

  // Bit 0 write timeout, bit 1 read timeout
  assign status_set = {evt_rd_i.timeout, evt_wr_i.timeout};
  assign status_clr = (wr_access && (reg_req_i.paddr == RegIrqStatus)) ?
                      reg_req_i.pwdata[1:0] : 2'b00;

  // Budget registers
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      budget_wr_q <= '0;
      budget_rd_q <= '0;
    end else if (wr_access) begin
      if (reg_req_i.paddr == RegBudgetWr) begin
        budget_wr_q <= reg_req_i.pwdata;
      end
      if (reg_req_i.paddr == RegBudgetRd) begin
        budget_rd_q <= reg_req_i.pwdata;
      end
    end
  end

  // Sticky status, a new timeout wins over a clear in the same cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      status_q <= '0;
    end else begin
      status_q <= (status_q & ~status_clr) | status_set;
    end
  end

  // Most recent offending address, write side first
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      irq_addr_q <= '0;
    end else if (evt_wr_i.timeout) begin
      irq_addr_q <= evt_wr_i.addr;
    end else if (evt_rd_i.timeout) begin
      irq_addr_q <= evt_rd_i.addr;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= |status_q;
    end
  end

  assign irq_o = irq_q;

  assign cfg_o.budget_write = budget_wr_q;
  assign cfg_o.budget_read  = budget_rd_q;

  // Read mux and decode, no wait states
  always_comb begin
    reg_rsp_o        = '0;
    reg_rsp_o.pready = 1'b1;
    mapped           = 1'b1;
    case (reg_req_i.paddr)
      RegBudgetWr:  reg_rsp_o.prdata = budget_wr_q;
      RegBudgetRd:  reg_rsp_o.prdata = budget_rd_q;
      RegIrqStatus: reg_rsp_o.prdata = DataWidth'(status_q);
      RegIrqAddr:   reg_rsp_o.prdata = DataWidth'(irq_addr_q);
      RegReset:     reg_rsp_o.prdata = DataWidth'(rst_pending_i);
      default: begin
        reg_rsp_o.prdata = '0;
        mapped           = 1'b0;
      end
    endcase
    // Unmapped offsets flag an error
    reg_rsp_o.pslverr = access && !mapped;
  end

endmodule

//--- src/txn_monitor.sv
// Transaction monitor timing outstanding requests of one direction against a tick budget
module txn_monitor import slv_guard_pkg::*; #(
  parameter int unsigned MaxTxns      = 4,
  parameter int unsigned CntWidth     = 16,
  parameter int unsigned PrescalerDiv = 4,
  parameter type         chan_t       = axil_aw_t
) (
  input  logic        clk_i,
  input  logic        arst_n_i,
  // Request accepted by the subordinate
  input  logic        start_i,
  input  chan_t       start_chan_i,
  // Response accepted by the manager
  input  logic        done_i,
  input  logic [31:0] budget_i,
  // Outside reset finished
  input  logic        reset_clear_i,
  output logic        full_o,
  output guard_evt_t  evt_o,
  output logic        reset_req_o
);

  localparam int unsigned PreWidth  = (PrescalerDiv > 1) ? $clog2(PrescalerDiv) : 1;
  localparam int unsigned PtrWidth  = (MaxTxns > 1) ? $clog2(MaxTxns) : 1;
  localparam int unsigned FillWidth = $clog2(MaxTxns + 1);

  typedef logic [CntWidth-1:0] tick_t;
  typedef logic [PtrWidth-1:0] ptr_t;

  logic [PreWidth-1:0]  pre_cnt_q;
  logic                 tick;
  tick_t                tick_cnt_q;

  tick_t                start_q [MaxTxns];
  logic [AddrWidth-1:0] addr_q  [MaxTxns];
  ptr_t                 wr_ptr_q;
  ptr_t                 rd_ptr_q;
  logic [FillWidth-1:0] fill_q;
  logic                 push;
  logic                 pop;
  logic                 empty;

  tick_t                head_age;
  logic                 expired;
  guard_evt_t           evt_q;
  logic                 reset_req_q;

  // Circular pointer increment, depth need not be a power of two
  function automatic ptr_t next_ptr(input ptr_t ptr);
    if (ptr == ptr_t'(MaxTxns - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Prescaler and free running tick counter
  assign tick = (pre_cnt_q == PreWidth'(PrescalerDiv - 1));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pre_cnt_q  <= '0;
      tick_cnt_q <= '0;
    end else if (tick) begin
      pre_cnt_q  <= '0;
      tick_cnt_q <= tick_cnt_q + 1'b1;
    end else begin
      pre_cnt_q  <= pre_cnt_q + 1'b1;
    end
  end

  // Queue of outstanding transactions
  assign empty  = (fill_q == '0);
  assign full_o = (fill_q == FillWidth'(MaxTxns));
  assign push   = start_i && !full_o && !reset_clear_i;
  // Stray responses on an empty queue are dropped
  assign pop    = done_i && !empty && !reset_clear_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      start_q[wr_ptr_q] <= tick_cnt_q;
      addr_q[wr_ptr_q]  <= start_chan_i.addr;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else if (reset_clear_i) begin
      // Subordinate was reset, nothing is outstanding anymore
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
    end
  end

  // Only the oldest entry can be the first to expire
  assign head_age = tick_cnt_q - start_q[rd_ptr_q];

  // Budget zero disables the check
  assign expired = !empty && (budget_i != '0) && (32'(head_age) > budget_i) &&
                   !reset_req_q && !evt_q.timeout && !reset_clear_i;

  // One cycle pulse, request follows a cycle later and holds until cleared
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      evt_q       <= '0;
      reset_req_q <= 1'b0;
    end else begin
      evt_q.timeout <= expired;
      if (expired) begin
        evt_q.addr <= addr_q[rd_ptr_q];
      end
      if (reset_clear_i) begin
        reset_req_q <= 1'b0;
      end else if (evt_q.timeout) begin
        reset_req_q <= 1'b1;
      end
    end
  end

  assign evt_o       = evt_q;
  assign reset_req_o = reset_req_q;

endmodule

//--- src/slv_guard_top.sv
// AXI4-Lite slave guard timing subordinate responses and isolating it on timeout
module slv_guard_top import slv_guard_pkg::*; #(
  parameter int unsigned MaxTxns      = 4,
  parameter int unsigned CntWidth     = 16,
  parameter int unsigned PrescalerDiv = 4
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      guard_ena_i,
  // Manager side
  input  axil_req_t req_i,
  output axil_rsp_t rsp_o,
  // Subordinate side
  output axil_req_t req_o,
  input  axil_rsp_t rsp_i,
  // Register bus
  input  apb_req_t  reg_req_i,
  output apb_rsp_t  reg_rsp_o,
  output logic      irq_o,
  // Reset handshake with the outside
  output logic      rst_req_o,
  input  logic      rst_stat_i
);

  guard_cfg_t cfg;
  guard_evt_t evt_wr;
  guard_evt_t evt_rd;

  logic wr_full;
  logic rd_full;
  logic wr_rst_req;
  logic rd_rst_req;
  logic rst_req;
  logic isolate;
  logic rst_clear;

  logic wr_start;
  logic wr_done;
  logic rd_start;
  logic rd_done;

  assign rst_req   = wr_rst_req | rd_rst_req;
  assign isolate   = guard_ena_i && rst_req;
  // Both queues are flushed once the subordinate has been reset
  assign rst_clear = rst_stat_i && rst_req;

  // Pass-through with back-pressure and isolation on top
  always_comb begin
    req_o = req_i;
    rsp_o = rsp_i;
    if (guard_ena_i) begin
      if (wr_full) begin
        req_o.aw_valid = 1'b0;
        rsp_o.aw_ready = 1'b0;
      end
      if (rd_full) begin
        req_o.ar_valid = 1'b0;
        rsp_o.ar_ready = 1'b0;
      end
    end
    if (isolate) begin
      req_o = '0;
      rsp_o = '0;
    end
  end

  // Write half, AW starts and B ends a transaction
  assign wr_start = guard_ena_i && req_o.aw_valid && rsp_i.aw_ready;
  assign wr_done  = guard_ena_i && rsp_i.b_valid && req_o.b_ready;

  // Read half, AR starts and R ends a transaction
  assign rd_start = guard_ena_i && req_o.ar_valid && rsp_i.ar_ready;
  assign rd_done  = guard_ena_i && rsp_i.r_valid && req_o.r_ready;

  txn_monitor #(
    .MaxTxns      ( MaxTxns      ),
    .CntWidth     ( CntWidth     ),
    .PrescalerDiv ( PrescalerDiv ),
    .chan_t       ( axil_aw_t    )
  ) u_wr_mon (
    .clk_i         ( clk_i            ),
    .arst_n_i      ( arst_n_i         ),
    .start_i       ( wr_start         ),
    .start_chan_i  ( req_o.aw         ),
    .done_i        ( wr_done          ),
    .budget_i      ( cfg.budget_write ),
    .reset_clear_i ( rst_clear        ),
    .full_o        ( wr_full          ),
    .evt_o         ( evt_wr           ),
    .reset_req_o   ( wr_rst_req       )
  );

  txn_monitor #(
    .MaxTxns      ( MaxTxns      ),
    .CntWidth     ( CntWidth     ),
    .PrescalerDiv ( PrescalerDiv ),
    .chan_t       ( axil_ar_t    )
  ) u_rd_mon (
    .clk_i         ( clk_i           ),
    .arst_n_i      ( arst_n_i        ),
    .start_i       ( rd_start        ),
    .start_chan_i  ( req_o.ar        ),
    .done_i        ( rd_done         ),
    .budget_i      ( cfg.budget_read ),
    .reset_clear_i ( rst_clear       ),
    .full_o        ( rd_full         ),
    .evt_o         ( evt_rd          ),
    .reset_req_o   ( rd_rst_req      )
  );

  slv_guard_regs u_regs (
    .clk_i         ( clk_i     ),
    .arst_n_i      ( arst_n_i  ),
    .reg_req_i     ( reg_req_i ),
    .reg_rsp_o     ( reg_rsp_o ),
    .cfg_o         ( cfg       ),
    .evt_wr_i      ( evt_wr    ),
    .evt_rd_i      ( evt_rd    ),
    .rst_pending_i ( rst_req   ),
    .irq_o         ( irq_o     )
  );

  assign rst_req_o = rst_req;

endmodule

//--- verification/axil_sub_model.sv
// Behavioral AXI4-Lite subordinate with a small word memory and a programmable response latency
module axil_sub_model import slv_guard_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  // Cycles from request accept to response valid, at least 1
  input  logic [7:0] latency_i,
  input  axil_req_t  req_i,
  output axil_rsp_t  rsp_o
);

  logic [DataWidth-1:0] mem [16];
  logic                 wr_busy_q;
  logic                 rd_busy_q;
  logic [7:0]           wr_cnt_q;
  logic [7:0]           rd_cnt_q;
  logic                 b_valid_q;
  logic                 r_valid_q;
  logic [DataWidth-1:0] r_data_q;
  logic                 aw_hs;
  logic                 ar_hs;

  // AW and W are taken in the same cycle
  assign aw_hs = !wr_busy_q && req_i.aw_valid && req_i.w_valid;
  assign ar_hs = !rd_busy_q && req_i.ar_valid;

  always_comb begin
    rsp_o          = '0;
    rsp_o.aw_ready = !wr_busy_q && req_i.w_valid;
    rsp_o.w_ready  = !wr_busy_q && req_i.aw_valid;
    rsp_o.b_valid  = b_valid_q;
    rsp_o.ar_ready = !rd_busy_q;
    rsp_o.r.data   = r_data_q;
    rsp_o.r_valid  = r_valid_q;
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      for (int i = 0; i < StrbWidth; i++) begin
        if (req_i.w.strb[i]) begin
          mem[req_i.aw.addr[5:2]][8*i +: 8] <= req_i.w.data[8*i +: 8];
        end
      end
    end
  end

  // Write side, count down then hold B until taken
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_busy_q <= 1'b0;
      wr_cnt_q  <= 8'd0;
      b_valid_q <= 1'b0;
    end else if (aw_hs) begin
      wr_busy_q <= 1'b1;
      wr_cnt_q  <= latency_i - 8'd1;
    end else if (wr_busy_q && !b_valid_q) begin
      if (wr_cnt_q == 8'd0) begin
        b_valid_q <= 1'b1;
      end else begin
        wr_cnt_q <= wr_cnt_q - 8'd1;
      end
    end else if (b_valid_q && req_i.b_ready) begin
      b_valid_q <= 1'b0;
      wr_busy_q <= 1'b0;
    end
  end

  // Read side, data is captured at AR accept
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_busy_q <= 1'b0;
      rd_cnt_q  <= 8'd0;
      r_valid_q <= 1'b0;
      r_data_q  <= '0;
    end else if (ar_hs) begin
      rd_busy_q <= 1'b1;
      rd_cnt_q  <= latency_i - 8'd1;
      r_data_q  <= mem[req_i.ar.addr[5:2]];
    end else if (rd_busy_q && !r_valid_q) begin
      if (rd_cnt_q == 8'd0) begin
        r_valid_q <= 1'b1;
      end else begin
        rd_cnt_q <= rd_cnt_q - 8'd1;
      end
    end else if (r_valid_q && req_i.r_ready) begin
      r_valid_q <= 1'b0;
      rd_busy_q <= 1'b0;
    end
  end

endmodule

//--- verification/tb_slv_guard.sv
// Testbench for the AXI4-Lite slave guard, table driven transactions with register checks
module tb_slv_guard import slv_guard_pkg::*; ();

  localparam int NumRows   = 12;
  localparam int TxnLimit  = 300;
  localparam int ApbLimit  = 10;
  localparam int ResetWait = 5;

  // One transaction per row
  typedef struct packed {
    logic        is_read;
    logic [31:0] addr;
    logic [31:0] data;
    logic [7:0]  latency;
    logic        ena;
    logic [31:0] budget;
    logic        expect_to;
  } row_t;

  logic        clk;
  logic        arst_n;
  logic        guard_ena;
  logic        rst_stat;
  logic        irq;
  logic        rst_req;
  logic [7:0]  sub_latency;
  axil_req_t   mgr_req;
  axil_rsp_t   mgr_rsp;
  axil_req_t   sub_req;
  axil_rsp_t   sub_rsp;
  apb_req_t    reg_req;
  apb_rsp_t    reg_rsp;

  row_t        rows [NumRows];
  logic [31:0] shadow [16];
  logic [31:0] lcg_state;
  int          err_cnt;
  int          timeout_cnt;

  slv_guard_top #(
    .MaxTxns      ( 4  ),
    .CntWidth     ( 16 ),
    .PrescalerDiv ( 4  )
  ) u_dut (
    .clk_i       ( clk       ),
    .arst_n_i    ( arst_n    ),
    .guard_ena_i ( guard_ena ),
    .req_i       ( mgr_req   ),
    .rsp_o       ( mgr_rsp   ),
    .req_o       ( sub_req   ),
    .rsp_i       ( sub_rsp   ),
    .reg_req_i   ( reg_req   ),
    .reg_rsp_o   ( reg_rsp   ),
    .irq_o       ( irq       ),
    .rst_req_o   ( rst_req   ),
    .rst_stat_i  ( rst_stat  )
  );

  axil_sub_model u_sub (
    .clk_i     ( clk         ),
    .arst_n_i  ( arst_n      ),
    .latency_i ( sub_latency ),
    .req_i     ( sub_req     ),
    .rsp_o     ( sub_rsp     )
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic finish_run();
    $display("Checks done with %0d errors and %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeout_cnt++;
    $display("Timeout at time %0t while waiting for %s", $time, what);
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("[ERROR] %0t: %s: got 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  // Setup phase, then access phase until pready
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
    int cnt;
    cnt = 0;
    @(negedge clk);
    reg_req.paddr   = addr;
    reg_req.psel    = 1'b1;
    reg_req.penable = 1'b0;
    reg_req.pwrite  = wr;
    reg_req.pwdata  = wdata;
    @(negedge clk);
    reg_req.penable = 1'b1;
    #1;
    while (!reg_rsp.pready) begin
      cnt++;
      if (cnt > ApbLimit) begin
        report_timeout("APB pready");
        break;
      end
      @(negedge clk);
      #1;
    end
    rdata  = reg_rsp.prdata;
    slverr = reg_rsp.pslverr;
    @(negedge clk);
    reg_req = '0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        slverr;
    apb_access(1'b1, addr, wdata, rdata, slverr);
    check_value($sformatf("pslverr on write to 0x%02h", addr), 32'(slverr), 32'd0);
  endtask

  task automatic apb_read_check(input logic [7:0] addr, input logic [31:0] exp,
                                input string what);
    logic [31:0] rdata;
    logic        slverr;
    apb_access(1'b0, addr, 32'd0, rdata, slverr);
    check_value(what, rdata, exp);
    check_value($sformatf("pslverr on read of 0x%02h", addr), 32'(slverr), 32'd0);
  endtask

  // Isolation checks, register view, then the reset done pulse
  task automatic service_reset(input logic is_read, input logic [31:0] addr);
    repeat (ResetWait) @(negedge clk);
    check_value("irq after timeout", 32'(irq), 32'd1);
    check_value("manager side isolated", 32'(mgr_rsp == '0), 32'd1);
    check_value("subordinate side isolated", 32'(sub_req == '0), 32'd1);
    apb_read_check(RegIrqStatus, is_read ? 32'd2 : 32'd1, "timeout status");
    apb_read_check(RegIrqAddr, addr, "captured address");
    apb_read_check(RegReset, 32'd1, "reset pending");
    rst_stat = 1'b1;
    @(negedge clk);
    rst_stat = 1'b0;
    check_value("reset request after reset done", 32'(rst_req), 32'd0);
  endtask

  task automatic axi_txn(input logic is_read, input logic [31:0] addr, input logic [31:0] wdata,
                         output logic [31:0] rdata, output logic saw_rst);
    int         cnt;
    logic       aw_hs;
    logic       w_hs;
    logic       ar_hs;
    logic       rsp_hs;
    logic [1:0] resp;
    cnt     = 0;
    aw_hs   = 1'b0;
    w_hs    = 1'b0;
    ar_hs   = 1'b0;
    rsp_hs  = 1'b0;
    resp    = 2'b00;
    rdata   = '0;
    saw_rst = 1'b0;
    @(negedge clk);
    if (is_read) begin
      mgr_req.ar.addr  = addr;
      mgr_req.ar_valid = 1'b1;
      mgr_req.r_ready  = 1'b1;
    end else begin
      mgr_req.aw.addr  = addr;
      mgr_req.aw_valid = 1'b1;
      mgr_req.w.data   = wdata;
      mgr_req.w.strb   = '1;
      mgr_req.w_valid  = 1'b1;
      mgr_req.b_ready  = 1'b1;
    end
    while (!rsp_hs) begin
      #1;
      // Transfers that complete on the coming rising edge
      aw_hs = aw_hs || (mgr_req.aw_valid && mgr_rsp.aw_ready);
      w_hs  = w_hs || (mgr_req.w_valid && mgr_rsp.w_ready);
      ar_hs = ar_hs || (mgr_req.ar_valid && mgr_rsp.ar_ready);
      if (mgr_rsp.b_valid && mgr_req.b_ready) begin
        rsp_hs = 1'b1;
        resp   = mgr_rsp.b.resp;
      end
      if (mgr_rsp.r_valid && mgr_req.r_ready) begin
        rsp_hs = 1'b1;
        resp   = mgr_rsp.r.resp;
        rdata  = mgr_rsp.r.data;
      end
      if (rst_req && !saw_rst) begin
        saw_rst = 1'b1;
        service_reset(is_read, addr);
      end else begin
        @(negedge clk);
      end
      if (aw_hs) mgr_req.aw_valid = 1'b0;
      if (w_hs) mgr_req.w_valid = 1'b0;
      if (ar_hs) mgr_req.ar_valid = 1'b0;
      cnt++;
      if (cnt > TxnLimit) begin
        report_timeout("an AXI response from the subordinate");
        break;
      end
    end
    mgr_req.b_ready = 1'b0;
    mgr_req.r_ready = 1'b0;
    check_value("AXI response code", 32'(resp), 32'd0);
  endtask

  // Reads expect the last data written to the same word
  task automatic add_row(input int idx, input logic is_read, input logic [31:0] addr,
                         input logic [7:0] latency, input logic ena, input logic [31:0] budget,
                         input logic expect_to);
    row_t row;
    row.is_read   = is_read;
    row.addr      = addr;
    row.latency   = latency;
    row.ena       = ena;
    row.budget    = budget;
    row.expect_to = expect_to;
    if (is_read) begin
      row.data = shadow[addr[5:2]];
    end else begin
      row.data             = lcg_next();
      shadow[addr[5:2]] = row.data;
    end
    rows[idx] = row;
  endtask

  task automatic build_table();
    // Short latencies under budget 8
    add_row(0, 1'b0, 32'h0000_0100, 8'd12, 1'b1, 32'd8, 1'b0);
    add_row(1, 1'b1, 32'h0000_0100, 8'd20, 1'b1, 32'd8, 1'b0);
    add_row(2, 1'b0, 32'h0000_0104, 8'd28, 1'b1, 32'd8, 1'b0);
    add_row(3, 1'b1, 32'h0000_0104, 8'd28, 1'b1, 32'd8, 1'b0);
    // Late responses that expire, read address differs from the write one
    add_row(4, 1'b0, 32'h0000_0108, 8'd48, 1'b1, 32'd8, 1'b1);
    add_row(5, 1'b1, 32'h0000_0100, 8'd48, 1'b1, 32'd8, 1'b1);
    // Guard off, then budget zero
    add_row(6, 1'b0, 32'h0000_010C, 8'd60, 1'b0, 32'd8, 1'b0);
    add_row(7, 1'b1, 32'h0000_010C, 8'd60, 1'b0, 32'd8, 1'b0);
    add_row(8, 1'b0, 32'h0000_0110, 8'd60, 1'b1, 32'd0, 1'b0);
    add_row(9, 1'b1, 32'h0000_0110, 8'd60, 1'b1, 32'd0, 1'b0);
    add_row(10, 1'b0, 32'h0000_0114, 8'd4, 1'b1, 32'd8, 1'b0);
    add_row(11, 1'b1, 32'h0000_0108, 8'd8, 1'b1, 32'd8, 1'b0);
  endtask

  task automatic run_row(input int idx, input row_t row);
    logic [31:0] rdata;
    logic        saw_rst;
    guard_ena   = row.ena;
    sub_latency = row.latency;
    apb_write(row.is_read ? RegBudgetRd : RegBudgetWr, row.budget);
    axi_txn(row.is_read, row.addr, row.data, rdata, saw_rst);
    check_value($sformatf("row %0d timeout seen", idx), 32'(saw_rst), 32'(row.expect_to));
    if (row.is_read) begin
      check_value($sformatf("row %0d read data", idx), rdata, row.data);
    end
    if (row.expect_to) begin
      apb_write(RegIrqStatus, row.is_read ? 32'd2 : 32'd1);
    end
    apb_read_check(RegIrqStatus, 32'd0, $sformatf("row %0d status at end", idx));
    apb_read_check(RegReset, 32'd0, $sformatf("row %0d reset pending at end", idx));
    check_value($sformatf("row %0d irq at end", idx), 32'(irq), 32'd0);
    check_value($sformatf("row %0d reset request at end", idx), 32'(rst_req), 32'd0);
  endtask

  initial begin
    logic [31:0] rdata;
    logic        slverr;
    logic [31:0] value;
    clk         = 1'b0;
    arst_n      = 1'b0;
    guard_ena   = 1'b1;
    rst_stat    = 1'b0;
    sub_latency = 8'd1;
    mgr_req     = '0;
    reg_req     = '0;
    err_cnt     = 0;
    timeout_cnt = 0;
    lcg_state   = 32'd99137;
    build_table();
    repeat (4) @(negedge clk);
    arst_n = 1'b1;

    // Register file after reset
    apb_read_check(RegBudgetWr, 32'd0, "write budget after reset");
    apb_read_check(RegBudgetRd, 32'd0, "read budget after reset");
    apb_read_check(RegIrqStatus, 32'd0, "status after reset");
    apb_read_check(RegReset, 32'd0, "reset pending after reset");
    value = lcg_next();
    apb_write(RegBudgetWr, value);
    apb_read_check(RegBudgetWr, value, "write budget readback");
    value = lcg_next();
    apb_write(RegBudgetRd, value);
    apb_read_check(RegBudgetRd, value, "read budget readback");
    apb_access(1'b0, 8'h14, 32'd0, rdata, slverr);
    check_value("pslverr at offset 0x14", 32'(slverr), 32'd1);

    for (int i = 0; i < NumRows; i++) begin
      run_row(i, rows[i]);
    end
    finish_run();
  end

endmodule

//--- sim.f
src/slv_guard_pkg.sv
src/slv_guard_regs.sv
src/txn_monitor.sv
src/slv_guard_top.sv
verification/axil_sub_model.sv
verification/tb_slv_guard.sv

//--- run_sim.sh
#!/bin/sh
# Build the slave guard testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
  --top-module tb_slv_guard \
  -Mdir build -o tb_slv_guard \
  -f sim.f

./build/tb_slv_guard > build/sim.log 2>&1 || true
cat build/sim.log

if grep -qx "TEST OK" build/sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
